//--- bench/eeprom_props.sv
`timescale 1ns/1ns
module eeprom_props import eeprom_pkg::*;
(
    input logic      CLK,
    input logic      RESET,
    input logic      ack,
    input logic      busy,
    input logic      scl,
    input logic      sda,
    input line_cmd_e line_cmd
);

    int fail_count = 0;

    ack_pulse: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
    else
    begin
        fail_count++;
        $error("ack stayed high for more than one cycle");
    end

    busy_with_ack: assert property (@(posedge CLK) disable iff (RESET) ack |-> busy)
    else
    begin
        fail_count++;
        $error("ack seen while busy was low");
    end

    // data bits only move while scl is low
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda)) |-> (line_cmd inside {cmd_start, cmd_stop}))
    else
    begin
        fail_count++;
        $error("sda changed while scl was high outside start or stop");
    end

endmodule

bind eeprom_master_top eeprom_props u_props (.CLK, .RESET, .ack, .busy, .scl, .sda,
                                             .line_cmd(u_line.cur_cmd));

//--- bench/eeprom_tb.sv
`timescale 1ns/1ns
module eeprom_tb;

    localparam int HALF_PERIOD = 4;
    localparam int ACK_LIMIT   = 128 * HALF_PERIOD + 64;   // a read is 78 half periods

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic        busy;
    logic        ack;
    logic        nack;
    logic [7:0]  rd_data;
    logic        scl;
    tri1         sda;

    logic [7:0]  ref_mem [0:2047];
    logic [7:0]  exp_rd = 'x;   // no read yet
    logic [31:0] rng = 32'd28315;
    logic [10:0] a;
    logic [10:0] last_wr = '0;
    int          mismatches = 0;
    int          failures = 0;
    int          extra_acks;

    eeprom_master_top #(.HALF_PERIOD(HALF_PERIOD)) dut (.CLK, .RESET, .wr, .rd, .addr,
        .wr_data, .busy, .ack, .nack, .rd_data, .scl, .sda);

    serial_eeprom_model eeprom (.scl, .sda);

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic pulse_req(input logic do_wr, input logic do_rd, input logic [10:0] ad,
                             input logic [7:0] d);
        @(posedge CLK);
        wr      <= do_wr;
        rd      <= do_rd;
        addr    <= ad;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        while (ack !== 1'b1 && n < ACK_LIMIT)
        begin
            @(posedge CLK);
            n++;
        end
        if (ack !== 1'b1)
        begin
            failures++;
            $display("no ack within %0d cycles", ACK_LIMIT);
        end
    endtask

    // one transfer, checked against the reference array
    task automatic run_op(input logic is_wr, input logic [10:0] ad, input logic [7:0] d);
        logic exp_nack;
        exp_nack = is_wr && (ad[10:8] == 3'd7);
        pulse_req(is_wr, !is_wr, ad, d);
        wait_ack();
        check_flag("nack", nack, exp_nack);
        if (is_wr && !exp_nack)
            ref_mem[ad] = d;
        if (!is_wr)
            exp_rd = ref_mem[ad];
        check_data("rd_data", rd_data, exp_rd);   // writes leave it alone
        @(posedge CLK);
        check_flag("busy", busy, 1'b0);
    endtask

    initial
    begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hff;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        check_flag("busy", busy, 1'b0);
        check_flag("ack", ack, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda", sda, 1'b1);

        rng = xorshift(rng);
        a = {1'b0, rng[9:0]};
        run_op(1'b1, a, rng[31:24]);
        run_op(1'b0, a, 8'h00);

        // protected block refuses data
        rng = xorshift(rng);
        a = {3'd7, rng[7:0]};
        run_op(1'b1, a, rng[31:24]);
        run_op(1'b0, a, 8'h00);

        // second strobe lands mid transfer
        pulse_req(1'b1, 1'b0, 11'h123, 8'h5a);
        repeat (4) @(posedge CLK);
        pulse_req(1'b1, 1'b1, 11'h124, 8'ha5);
        wait_ack();
        check_flag("nack", nack, 1'b0);
        ref_mem[11'h123] = 8'h5a;
        extra_acks = 0;
        repeat (ACK_LIMIT)
        begin
            @(posedge CLK);
            if (ack === 1'b1)
                extra_acks++;
        end
        if (extra_acks != 0)
        begin
            failures++;
            $display("strobe during busy started %0d extra transfers", extra_acks);
        end
        run_op(1'b0, 11'h124, 8'h00);
        run_op(1'b0, 11'h123, 8'h00);

        for (int i = 0; i < 200; i++)
        begin
            rng = xorshift(rng);
            a = rng[1] ? last_wr : rng[18:8];
            run_op(rng[0], a, rng[31:24]);
            if (rng[0])
                last_wr = a;
        end

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, dut.u_props.fail_count);
        if (mismatches == 0 && failures == 0 && dut.u_props.fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- bench/serial_eeprom_model.sv
`timescale 1ns/1ns
module serial_eeprom_model
(
    input  logic scl,
    inout  wire  sda
);

    logic [7:0]  mem [0:2047];
    logic        sda_low   = 1'b0;
    logic        in_xfer   = 1'b0;
    logic        reading   = 1'b0;
    logic        read_next = 1'b0;   // control byte asked for a read
    logic [3:0]  bit_cnt   = '0;     // rising scl edges in this byte
    logic [1:0]  byte_cnt  = '0;
    logic [7:0]  shift;
    logic [7:0]  out_byte;
    logic [10:0] ptr;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
    end

    // sda moving under a high scl is start or stop
    always @(sda)
    begin
        if (scl === 1'b1)
        begin
            in_xfer  = !sda;   // falling edge starts
            reading  = 1'b0;
            bit_cnt  = '0;
            byte_cnt = '0;
        end
    end

    always @(posedge scl)
    begin
        if (in_xfer)
        begin
            shift   = {shift[6:0], sda};
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (in_xfer)
        begin
            if (bit_cnt == 4'd9)
            begin
                sda_low   = 1'b0;   // ninth clock over
                bit_cnt   = '0;
                byte_cnt  = byte_cnt + 2'd1;
                reading   = read_next;
                read_next = 1'b0;
                out_byte  = mem[ptr];
                if (reading)
                    sda_low = !out_byte[7];
            end
            else if (reading)
            begin
                out_byte = {out_byte[6:0], 1'b1};   // ones release the line
                sda_low  = !out_byte[7];
            end
            else if (bit_cnt == 4'd8)
            begin
                case (byte_cnt)
                    2'd0:
                        if (shift[7:4] == 4'b1010)
                        begin
                            ptr[10:8] = shift[3:1];
                            read_next = shift[0];
                            sda_low   = 1'b1;
                        end
                    2'd1:
                    begin
                        ptr[7:0] = shift;
                        sda_low  = 1'b1;
                    end
                    2'd2:
                        if (ptr[10:8] != 3'd7)   // top block is write protected
                        begin
                            mem[ptr] = shift;
                            sda_low  = 1'b1;
                        end
                    default:
                        sda_low = 1'b0;
                endcase
            end
        end
    end

endmodule

//--- list.f
source/eeprom_pkg.sv
source/request_capture.sv
source/line_engine.sv
source/transfer_sequencer.sv
source/result_port.sv
source/eeprom_master_top.sv
bench/serial_eeprom_model.sv
bench/eeprom_props.sv
bench/eeprom_tb.sv

//--- source/eeprom_master_top.sv
`timescale 1ns/1ns
module eeprom_master_top import eeprom_pkg::*;
#(
    parameter int HALF_PERIOD = 4
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wr_data,
    output logic        busy,
    output logic        ack,
    output logic        nack,
    output logic [7:0]  rd_data,
    output logic        scl,
    inout  wire         sda
);

    logic        req_valid;
    eeprom_op_e  req_op;
    logic [10:0] req_addr;
    logic [7:0]  req_data;
    logic        seq_done;
    logic        seq_failed;
    logic        seq_is_read;
    logic        cmd_valid;
    line_cmd_e   cmd;
    logic [7:0]  tx_byte;
    logic        cmd_done;
    logic        rx_nack;
    logic [7:0]  rx_byte;

    request_capture u_req (.CLK, .RESET, .wr, .rd, .addr, .wr_data, .seq_done,
                           .busy, .req_valid, .req_op, .req_addr, .req_data);

    transfer_sequencer u_seq (.CLK, .RESET, .req_valid, .req_op, .req_addr, .req_data,
                              .cmd_done, .rx_nack, .cmd_valid, .cmd, .tx_byte,
                              .seq_done, .seq_failed, .seq_is_read);

    line_engine #(.HALF_PERIOD(HALF_PERIOD)) u_line (
        .CLK, .RESET, .cmd_valid, .cmd, .tx_byte,
        .cmd_done, .rx_nack, .rx_byte, .scl, .sda
    );

    result_port u_res (.CLK, .RESET, .seq_done, .seq_failed, .seq_is_read, .rx_byte,
                       .ack, .nack, .rd_data);

endmodule

//--- source/eeprom_pkg.sv
package eeprom_pkg;

    // kind of request taken from the user side
    typedef enum logic
    {
        op_write,
        op_read
    } eeprom_op_e;

    // transfer sequencer states
    typedef enum logic [3:0]
    {
        idle,
        send_start,
        send_ctrl_w,
        send_addr,
        send_data,
        send_restart,
        send_ctrl_r,
        recv_data,
        send_stop,
        finish
    } seq_state_e;

    // bit level commands to the line engine
    typedef enum logic [1:0]
    {
        cmd_start,
        cmd_stop,
        cmd_tx_byte,
        cmd_rx_byte
    } line_cmd_e;

    localparam logic [3:0] DEVICE_CODE = 4'b1010; // upper nibble of control byte

endpackage

//--- source/line_engine.sv
`timescale 1ns/1ns
module line_engine import eeprom_pkg::*;
#(
    parameter int HALF_PERIOD = 4
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_valid,
    input  line_cmd_e  cmd,
    input  logic [7:0] tx_byte,
    output logic       cmd_done,
    output logic       rx_nack,
    output logic [7:0] rx_byte,
    output logic       scl,
    inout  wire        sda
);

    localparam int CNT_W = $clog2(HALF_PERIOD);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(HALF_PERIOD - 1);
    // sda moves one cycle or more after the scl edge
    localparam logic [CNT_W-1:0] MID_CNT = CNT_W'((HALF_PERIOD - 1) / 2);

    logic             active;
    line_cmd_e        cur_cmd;
    logic [CNT_W-1:0] hp_cnt;
    logic [4:0]       ph;        // half period index, odd ones have scl high
    logic [4:0]       last_ph;
    logic [7:0]       tx_sh;
    logic             sda_low;
    logic             half_end;
    logic             mid_pt;
    logic             is_byte;

    assign sda      = sda_low ? 1'b0 : 1'bz;   // open drain
    assign is_byte  = (cur_cmd == cmd_tx_byte) || (cur_cmd == cmd_rx_byte);
    assign last_ph  = is_byte ? 5'd17 : 5'd1;
    assign half_end = (hp_cnt == LAST_CNT);
    assign mid_pt   = (hp_cnt == MID_CNT);

    // scl and phase pacing
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            cur_cmd  <= cmd_start;
            hp_cnt   <= '0;
            ph       <= '0;
            scl      <= 1'b1;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active  <= 1'b1;
                    cur_cmd <= cmd;
                    hp_cnt  <= '0;
                    ph      <= '0;
                    scl     <= 1'b0;   // every command opens low
                end
            end
            else if (half_end)
            begin
                hp_cnt <= '0;
                if (ph == last_ph)
                begin
                    active   <= 1'b0;   // scl left high
                    cmd_done <= 1'b1;
                end
                else
                begin
                    ph  <= ph + 5'd1;
                    scl <= ~ph[0];
                end
            end
            else
                hp_cnt <= hp_cnt + 1'b1;
        end
    end

    // sda drive and acknowledge sampling
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            sda_low <= 1'b0;
            rx_nack <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_valid)
                rx_nack <= 1'b0;
        end
        else if (mid_pt)
        begin
            case (cur_cmd)
                cmd_start:
                    sda_low <= ph[0];    // falls while scl high
                cmd_stop:
                    sda_low <= ~ph[0];   // rises while scl high
                cmd_tx_byte:
                    if (ph == 5'd17)
                        rx_nack <= sda;  // released line means no ack
                    else if (!ph[0])
                        sda_low <= (ph != 5'd16) && !tx_sh[7];
                default:
                    sda_low <= 1'b0;     // read bits, then our nack
            endcase
        end
    end

    // data shift registers
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
            tx_sh <= tx_byte;
        else if (active && mid_pt && ph[0])
        begin
            if (cur_cmd == cmd_tx_byte)
                tx_sh <= {tx_sh[6:0], 1'b0};
            if (cur_cmd == cmd_rx_byte && ph != 5'd17)
                rx_byte <= {rx_byte[6:0], sda};   // msb first
        end
    end

endmodule

//--- source/request_capture.sv
`timescale 1ns/1ns
module request_capture import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wr_data,
    input  logic        seq_done,
    output logic        busy,
    output logic        req_valid,
    output eeprom_op_e  req_op,
    output logic [10:0] req_addr,
    output logic [7:0]  req_data
);

    logic valid_q;   // req_valid one cycle late, covers the ack cycle
    logic accept;

    assign busy   = req_valid | valid_q;
    assign accept = !busy && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            req_valid <= 1'b0;
            valid_q   <= 1'b0;
        end
        else
        begin
            valid_q <= req_valid;
            if (seq_done)
                req_valid <= 1'b0;
            else if (accept)
                req_valid <= 1'b1;
        end
    end

    // operands held for the whole transfer
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_op   <= wr ? op_write : op_read;   // wr wins
            req_addr <= addr;
            req_data <= wr_data;
        end
    end

endmodule

//--- source/result_port.sv
`timescale 1ns/1ns
module result_port
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       seq_done,
    input  logic       seq_failed,
    input  logic       seq_is_read,
    input  logic [7:0] rx_byte,
    output logic       ack,
    output logic       nack,
    output logic [7:0] rd_data
);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            ack  <= 1'b0;
            nack <= 1'b0;
        end
        else
        begin
            ack <= seq_done;   // one cycle pulse
            if (seq_done)
                nack <= seq_failed;   // held until next completion
        end
    end

    // only a good read updates the data
    always_ff @(posedge CLK)
    begin
        if (seq_done && seq_is_read && !seq_failed)
            rd_data <= rx_byte;
    end

endmodule

//--- source/transfer_sequencer.sv
`timescale 1ns/1ns
module transfer_sequencer import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  eeprom_op_e  req_op,
    input  logic [10:0] req_addr,
    input  logic [7:0]  req_data,
    input  logic        cmd_done,
    input  logic        rx_nack,
    output logic        cmd_valid,
    output line_cmd_e   cmd,
    output logic [7:0]  tx_byte,
    output logic        seq_done,
    output logic        seq_failed,
    output logic        seq_is_read
);

    seq_state_e state;
    logic [7:0] ctrl_w;
    logic [7:0] ctrl_r;

    // block select rides in the control byte
    assign ctrl_w      = {DEVICE_CODE, req_addr[10:8], 1'b0};
    assign ctrl_r      = {DEVICE_CODE, req_addr[10:8], 1'b1};
    assign seq_is_read = (req_op == op_read);   // request held until seq_done

    task automatic issue(input seq_state_e nxt, input line_cmd_e c, input logic [7:0] b);
        state     <= nxt;
        cmd_valid <= 1'b1;
        cmd       <= c;
        tx_byte   <= b;
    endtask

    // slave refused a byte, close the bus
    task automatic abort_xfer();
        seq_failed <= 1'b1;
        issue(send_stop, cmd_stop, 8'h00);
    endtask

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= idle;
            cmd_valid  <= 1'b0;
            cmd        <= cmd_start;
            tx_byte    <= '0;
            seq_done   <= 1'b0;
            seq_failed <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            seq_done  <= 1'b0;
            if (state == idle)
            begin
                if (req_valid)
                begin
                    seq_failed <= 1'b0;
                    issue(send_start, cmd_start, 8'h00);
                end
            end
            else if (state == finish)
                state <= idle;
            else if (cmd_done)
            begin
                case (state)
                    send_start:
                        issue(send_ctrl_w, cmd_tx_byte, ctrl_w);
                    send_ctrl_w:
                        if (rx_nack)
                            abort_xfer();
                        else
                            issue(send_addr, cmd_tx_byte, req_addr[7:0]);
                    send_addr:
                        if (rx_nack)
                            abort_xfer();
                        else if (req_op == op_write)
                            issue(send_data, cmd_tx_byte, req_data);
                        else
                            issue(send_restart, cmd_start, 8'h00);
                    send_data:
                    begin
                        seq_failed <= rx_nack;   // protected block ends here
                        issue(send_stop, cmd_stop, 8'h00);
                    end
                    send_restart:
                        issue(send_ctrl_r, cmd_tx_byte, ctrl_r);
                    send_ctrl_r:
                        if (rx_nack)
                            abort_xfer();
                        else
                            issue(recv_data, cmd_rx_byte, 8'h00);
                    recv_data:
                        issue(send_stop, cmd_stop, 8'h00);
                    send_stop:
                    begin
                        state    <= finish;
                        seq_done <= 1'b1;
                    end
                    default:
                        state <= idle;
                endcase
            end
        end
    end

endmodule
